/* design/hash_table_params.svh */
`ifndef HASH_TABLE_PARAMS_SVH
`define HASH_TABLE_PARAMS_SVH

// key and payload widths
`define HT_KEY_WIDTH 8
`define HT_DATA_WIDTH 16

// table geometry, all tables share one address width
`define HT_NUM_TABLES 2
`define HT_ADR_WIDTH 3  // 8 slots per table

`endif

/* design/hash_table_pkg.sv */
`include "hash_table_params.svh"

package hash_table_pkg;

    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_READ   = 2'd1,
        OP_WRITE  = 2'd2,
        OP_DELETE = 2'd3
    } op_e;

    typedef struct packed {
        op_e                       op;
        logic [`HT_KEY_WIDTH-1:0]  key;
        logic [`HT_DATA_WIDTH-1:0] data;
    } op_req_t;

    typedef struct packed {
        logic                      valid;
        logic [`HT_KEY_WIDTH-1:0]  key;
        logic [`HT_DATA_WIDTH-1:0] data;
    } entry_t;

    // a delete is a write with entry.valid low
    typedef struct packed {
        logic                     en;
        logic [`HT_ADR_WIDTH-1:0] adr;
        entry_t                   entry;
    } tbl_wr_t;

    // one row per key bit, row 0 belongs to key bit 0
    localparam logic [`HT_ADR_WIDTH-1:0] h3_matrix [`HT_NUM_TABLES][`HT_KEY_WIDTH] = '{
        '{3'h1, 3'h2, 3'h4, 3'h3, 3'h6, 3'h5, 3'h7, 3'h1},
        '{3'h5, 3'h3, 3'h6, 3'h1, 3'h4, 3'h7, 3'h2, 3'h6}
    };

endpackage

/* design/h3_hash.sv */
`timescale 1ns/1ns

`include "hash_table_params.svh"

module h3_hash #(
    parameter int table_idx = 0
) (
    input  logic [`HT_KEY_WIDTH-1:0] key_i,
    output logic [`HT_ADR_WIDTH-1:0] adr_o
);

    // xor of the matrix rows picked by the set key bits
    always_comb begin
        adr_o = '0;
        for (int b = 0; b < `HT_KEY_WIDTH; b++) begin
            if (key_i[b]) begin
                adr_o = adr_o ^ hash_table_pkg::h3_matrix[table_idx][b];
            end
        end
    end

endmodule

/* design/bucket_store.sv */
`timescale 1ns/1ns

`include "hash_table_params.svh"

module bucket_store (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     en_i,
    input  logic [`HT_ADR_WIDTH-1:0] rd_adr_i,
    input  hash_table_pkg::tbl_wr_t  wr_i,
    output hash_table_pkg::entry_t   entry_o
);

    localparam int num_slots = 1 << `HT_ADR_WIDTH;

    logic [`HT_KEY_WIDTH-1:0]  key_mem  [num_slots];
    logic [`HT_DATA_WIDTH-1:0] data_mem [num_slots];
    logic [num_slots-1:0]      valid_q;

    logic                      rd_valid_q;
    logic [`HT_KEY_WIDTH-1:0]  rd_key_q;
    logic [`HT_DATA_WIDTH-1:0] rd_data_q;

    // slot payload, no reset
    always_ff @(posedge clk) begin
        if (en_i) begin
            rd_key_q  <= key_mem[rd_adr_i];   // read before write on a shared edge
            rd_data_q <= data_mem[rd_adr_i];
            if (wr_i.en) begin
                key_mem[wr_i.adr]  <= wr_i.entry.key;
                data_mem[wr_i.adr] <= wr_i.entry.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            rd_valid_q <= 1'b0;
        end else if (en_i) begin
            rd_valid_q <= valid_q[rd_adr_i];
            if (wr_i.en) begin
                valid_q[wr_i.adr] <= wr_i.entry.valid;
            end
        end
    end

    assign entry_o = '{valid: rd_valid_q, key: rd_key_q, data: rd_data_q};

endmodule

/* design/forward_unit.sv */
`timescale 1ns/1ns

`include "hash_table_params.svh"

module forward_unit (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     en_i,
    input  logic [`HT_ADR_WIDTH-1:0] adr_i   [`HT_NUM_TABLES],
    input  hash_table_pkg::entry_t   entry_i [`HT_NUM_TABLES],
    input  hash_table_pkg::tbl_wr_t  wr_i    [`HT_NUM_TABLES],
    output hash_table_pkg::entry_t   entry_o [`HT_NUM_TABLES]
);

    hash_table_pkg::tbl_wr_t wr_q [`HT_NUM_TABLES];

    // write that landed in the store on the last enabled edge
    always_ff @(posedge clk) begin
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            if (!rst_n_i) begin
                wr_q[t].en <= 1'b0;
            end else if (en_i) begin
                wr_q[t] <= wr_i[t];
            end
        end
    end

    // the store read that slot one edge too early, so its data is stale
    always_comb begin
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            if (wr_q[t].en && (wr_q[t].adr == adr_i[t])) begin
                entry_o[t] = wr_q[t].entry;
            end else begin
                entry_o[t] = entry_i[t];
            end
        end
    end

endmodule

/* design/table_controller.sv */
`timescale 1ns/1ns

`include "hash_table_params.svh"

module table_controller (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      en_i,
    input  hash_table_pkg::op_req_t   req_i,
    input  logic [`HT_ADR_WIDTH-1:0]  adr_i   [`HT_NUM_TABLES],
    input  hash_table_pkg::entry_t    entry_i [`HT_NUM_TABLES],
    output hash_table_pkg::tbl_wr_t   wr_o    [`HT_NUM_TABLES],
    output logic                      valid_o,
    output logic                      no_deletion_target_o,
    output logic                      no_write_space_o,
    output logic                      no_element_found_o,
    output logic                      key_already_present_o,
    output logic [`HT_DATA_WIDTH-1:0] read_data_o
);

    logic [`HT_NUM_TABLES-1:0] hit;
    logic [`HT_NUM_TABLES-1:0] free;
    logic [`HT_NUM_TABLES-1:0] hit_sel;   // lowest hit, one hot
    logic [`HT_NUM_TABLES-1:0] free_sel;  // lowest free slot, one hot
    logic                      any_hit;
    logic                      any_free;
    logic [`HT_DATA_WIDTH-1:0] hit_data;
    logic                      is_read;
    logic                      is_write;
    logic                      is_delete;

    always_comb begin
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            hit[t]  = entry_i[t].valid && (entry_i[t].key == req_i.key);
            free[t] = !entry_i[t].valid;
        end
    end

    assign hit_sel   = hit & (~hit + 1'b1);
    assign free_sel  = free & (~free + 1'b1);
    assign any_hit   = |hit;
    assign any_free  = |free;
    assign is_read   = (req_i.op == hash_table_pkg::OP_READ);
    assign is_write  = (req_i.op == hash_table_pkg::OP_WRITE);
    assign is_delete = (req_i.op == hash_table_pkg::OP_DELETE);

    always_comb begin
        hit_data = '0;
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            if (hit_sel[t]) begin
                hit_data = entry_i[t].data;
            end
        end
    end

    // at most one table sees en per request
    always_comb begin
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            wr_o[t].adr         = adr_i[t];
            wr_o[t].entry.valid = !is_delete;
            wr_o[t].entry.key   = req_i.key;
            wr_o[t].entry.data  = req_i.data;
            wr_o[t].en          = (is_write && !any_hit && free_sel[t]) ||
                                  (is_delete && hit_sel[t]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o               <= 1'b0;
            no_deletion_target_o  <= 1'b0;
            no_write_space_o      <= 1'b0;
            no_element_found_o    <= 1'b0;
            key_already_present_o <= 1'b0;
            read_data_o           <= '0;
        end else if (en_i) begin
            valid_o               <= (req_i.op != hash_table_pkg::OP_NONE);
            no_deletion_target_o  <= is_delete && !any_hit;
            no_write_space_o      <= is_write && !any_hit && !any_free;
            no_element_found_o    <= is_read && !any_hit;
            key_already_present_o <= is_write && any_hit;
            read_data_o           <= (is_read && any_hit) ? hit_data : '0;
        end
    end

endmodule

/* design/hash_table.sv */
`timescale 1ns/1ns

`include "hash_table_params.svh"

module hash_table (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      valid_i,
    input  logic                      ready_i,
    input  hash_table_pkg::op_e       op_i,
    input  logic [`HT_KEY_WIDTH-1:0]  key_i,
    input  logic [`HT_DATA_WIDTH-1:0] data_i,
    output logic                      ready_o,
    output logic                      valid_o,
    output logic                      no_deletion_target_o,
    output logic                      no_write_space_o,
    output logic                      no_element_found_o,
    output logic                      key_already_present_o,
    output logic [`HT_DATA_WIDTH-1:0] read_data_o
);

    hash_table_pkg::op_req_t  req_d;
    hash_table_pkg::op_req_t  req_q1;
    hash_table_pkg::op_req_t  req_q2;
    logic [`HT_ADR_WIDTH-1:0] adr_d  [`HT_NUM_TABLES];
    logic [`HT_ADR_WIDTH-1:0] adr_q1 [`HT_NUM_TABLES];
    logic [`HT_ADR_WIDTH-1:0] adr_q2 [`HT_NUM_TABLES];  // address the store data was read at
    hash_table_pkg::entry_t   raw_entry [`HT_NUM_TABLES];
    hash_table_pkg::entry_t   fwd_entry [`HT_NUM_TABLES];
    hash_table_pkg::tbl_wr_t  tbl_wr    [`HT_NUM_TABLES];

    assign ready_o = ready_i;
    assign req_d   = '{op: valid_i ? op_i : hash_table_pkg::OP_NONE, key: key_i, data: data_i};

    // ready_i acts as the clock enable of every stage
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_q1.op <= hash_table_pkg::OP_NONE;
            req_q2.op <= hash_table_pkg::OP_NONE;
        end else if (ready_i) begin
            req_q1 <= req_d;
            req_q2 <= req_q1;
            adr_q1 <= adr_d;
            adr_q2 <= adr_q1;
        end
    end

    for (genvar t = 0; t < `HT_NUM_TABLES; t++) begin : g_table
        h3_hash #(.table_idx(t)) hash_inst (
            .key_i (key_i),
            .adr_o (adr_d[t])
        );

        bucket_store store_inst (
            .clk      (clk),
            .rst_n_i  (rst_n_i),
            .en_i     (ready_i),
            .rd_adr_i (adr_q1[t]),
            .wr_i     (tbl_wr[t]),
            .entry_o  (raw_entry[t])
        );
    end

    forward_unit forward_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .en_i    (ready_i),
        .adr_i   (adr_q2),
        .entry_i (raw_entry),
        .wr_i    (tbl_wr),
        .entry_o (fwd_entry)
    );

    table_controller controller_inst (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .en_i                  (ready_i),
        .req_i                 (req_q2),
        .adr_i                 (adr_q2),
        .entry_i               (fwd_entry),
        .wr_o                  (tbl_wr),
        .valid_o               (valid_o),
        .no_deletion_target_o  (no_deletion_target_o),
        .no_write_space_o      (no_write_space_o),
        .no_element_found_o    (no_element_found_o),
        .key_already_present_o (key_already_present_o),
        .read_data_o           (read_data_o)
    );

endmodule

/* dv/hash_table_asserts.sv */
`timescale 1ns/1ns

`include "hash_table_params.svh"

module hash_table_asserts (
    input logic                      clk,
    input logic                      rst_n_i,
    input logic                      valid_i,
    input logic                      ready_i,
    input hash_table_pkg::op_e       op_i,
    input logic                      out_valid_i,
    input logic [3:0]                status_i,
    input logic [`HT_DATA_WIDTH-1:0] read_data_i
);

    logic [2:0] accept_q;  // one bit per enabled stage
    int         fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            accept_q <= '0;
        end else if (ready_i) begin
            accept_q <= {accept_q[1:0], valid_i && (op_i != hash_table_pkg::OP_NONE)};
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        out_valid_i == accept_q[2])
    else begin
        $error("valid_o is not 3 enabled cycles after an accepted request");
        fail_count = fail_count + 1;
    end

    a_one_status: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(status_i))
    else begin
        $error("more than one status strobe is high");
        fail_count = fail_count + 1;
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |=> !out_valid_i && status_i == '0 && read_data_i == '0)
    else begin
        $error("outputs are not quiet after reset");
        fail_count = fail_count + 1;
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        !ready_i |=> $stable({out_valid_i, status_i, read_data_i}))
    else begin
        $error("outputs changed while ready_i was low");
        fail_count = fail_count + 1;
    end

endmodule

bind hash_table hash_table_asserts asserts_inst (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .ready_i     (ready_i),
    .op_i        (op_i),
    .out_valid_i (valid_o),
    .status_i    ({no_deletion_target_o, no_write_space_o,
                   no_element_found_o, key_already_present_o}),
    .read_data_i (read_data_o)
);

/* dv/hash_table_tb.sv */
`timescale 1ns/1ns

`include "hash_table_params.svh"

module hash_table_tb;

    localparam int num_reqs  = 54;
    localparam int cycle_max = 3 * num_reqs + 50;
    localparam int kw        = `HT_KEY_WIDTH;
    localparam int dw        = `HT_DATA_WIDTH;
    localparam int num_slots = 1 << `HT_ADR_WIDTH;

    typedef struct packed {
        logic          no_del;
        logic          no_space;
        logic          not_found;
        logic          present;
        logic [dw-1:0] data;
    } result_t;

    logic                clk = 1'b0;
    logic                rst_n_i;
    logic                valid_i;
    logic                ready_i;
    hash_table_pkg::op_e op_i;
    logic [kw-1:0]       key_i;
    logic [dw-1:0]       data_i;
    logic                ready_o;
    logic                valid_o;
    logic                no_deletion_target_o;
    logic                no_write_space_o;
    logic                no_element_found_o;
    logic                key_already_present_o;
    logic [dw-1:0]       read_data_o;

    logic [15:0]   lfsr_q = 16'd77;
    logic          en_q = 1'b0;  // last edge advanced the pipeline
    int            val_errors = 0;
    int            other_errors = 0;
    int            cycles = 0;
    result_t       exp_q [$];
    string         name_q [$];
    string         test_name;
    logic          ref_valid [`HT_NUM_TABLES][num_slots];
    logic [kw-1:0] ref_key   [`HT_NUM_TABLES][num_slots];
    logic [dw-1:0] ref_data  [`HT_NUM_TABLES][num_slots];
    logic [kw-1:0] keys [8];  // 0..2 share one slot pair, 3..6 plain, 7 forwarding

    hash_table hash_table_inst (.*);

    always #2 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[14:0], lfsr_q[0]};
        end
    endtask

    // xor of the h3 matrix rows whose key bit is set
    function automatic logic [`HT_ADR_WIDTH-1:0] slot_of(input int t, input logic [kw-1:0] k);
        logic [`HT_ADR_WIDTH-1:0] a;
        a = '0;
        for (int b = 0; b < kw; b++) begin
            if (k[b]) begin
                a = a ^ hash_table_pkg::h3_matrix[t][b];
            end
        end
        return a;
    endfunction

    task automatic find_same_slot();
        int n;
        for (int i = 0; i < (1 << kw); i++) begin
            n = 0;
            for (int j = i; j < (1 << kw); j++) begin
                if (n < 3 && slot_of(0, kw'(i)) == slot_of(0, kw'(j)) &&
                    slot_of(1, kw'(i)) == slot_of(1, kw'(j))) begin
                    keys[n] = kw'(j);
                    n = n + 1;
                end
            end
            if (n == 3) begin
                return;
            end
        end
    endtask

    task automatic model_op(input hash_table_pkg::op_e op, input logic [kw-1:0] k,
                            input logic [dw-1:0] d, output result_t res);
        int hit_t;
        int free_t;
        logic [`HT_ADR_WIDTH-1:0] a;
        res = '0;
        hit_t = -1;
        free_t = -1;
        for (int t = `HT_NUM_TABLES - 1; t >= 0; t--) begin  // lowest index ends up chosen
            a = slot_of(t, k);
            if (ref_valid[t][a] && ref_key[t][a] == k) begin
                hit_t = t;
            end
            if (!ref_valid[t][a]) begin
                free_t = t;
            end
        end
        case (op)
            hash_table_pkg::OP_READ: begin
                if (hit_t >= 0) begin
                    res.data = ref_data[hit_t][slot_of(hit_t, k)];
                end else begin
                    res.not_found = 1'b1;
                end
            end
            hash_table_pkg::OP_WRITE: begin
                if (hit_t >= 0) begin
                    res.present = 1'b1;
                end else if (free_t < 0) begin
                    res.no_space = 1'b1;
                end else begin
                    a = slot_of(free_t, k);
                    ref_valid[free_t][a] = 1'b1;
                    ref_key[free_t][a] = k;
                    ref_data[free_t][a] = d;
                end
            end
            hash_table_pkg::OP_DELETE: begin
                if (hit_t >= 0) begin
                    ref_valid[hit_t][slot_of(hit_t, k)] = 1'b0;
                end else begin
                    res.no_del = 1'b1;
                end
            end
            default: ;
        endcase
    endtask

    // the request shows during the stalled cycles and is taken on the last one
    task automatic send(input hash_table_pkg::op_e op, input logic [kw-1:0] k,
                        input logic [dw-1:0] d, input int stalls);
        result_t res;
        for (int i = 0; i <= stalls; i++) begin
            @(negedge clk);
            ready_i = (i == stalls);
            valid_i = 1'b1;
            op_i    = op;
            key_i   = k;
            data_i  = d;
        end
        model_op(op, k, d, res);
        if (op != hash_table_pkg::OP_NONE) begin
            exp_q.push_back(res);
            name_q.push_back(test_name);
        end
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            valid_i = 1'b0;
            ready_i = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        assert (ready_o == ready_i) else begin
            $display("Fail %s: ready_o expected %b, actual %b", test_name, ready_i, ready_o);
            val_errors++;
        end
        en_q <= ready_i;
        cycles = cycles + 1;
        if (cycles >= cycle_max) begin
            $display("timeout, no end of test after %0d cycles", cycle_max);
            $display("tests failed");
            $finish;
        end
    end

    always @(negedge clk) begin : check_results
        result_t exp;
        result_t got;
        string   name;
        if (en_q && valid_o) begin
            if (exp_q.size() == 0) begin
                $display("result came out with no request outstanding");
                other_errors++;
            end else begin
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                got  = {no_deletion_target_o, no_write_space_o, no_element_found_o,
                        key_already_present_o, read_data_o};
                assert (got == exp) else begin
                    $display("Fail %s: expected %h, actual %h", name, exp, got);
                    val_errors++;
                end
            end
        end
    end

    initial begin : run_tests
        logic [15:0]   r;
        logic [15:0]   d;
        logic [kw-1:0] k;
        int            assert_fails;
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        ready_i = 1'b1;
        op_i    = hash_table_pkg::OP_NONE;
        key_i   = '0;
        data_i  = '0;
        for (int t = 0; t < `HT_NUM_TABLES; t++) begin
            for (int s = 0; s < num_slots; s++) begin
                ref_valid[t][s] = 1'b0;
            end
        end
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;

        test_name = "same_slot";  // fills table 0, then table 1, then runs out
        find_same_slot();
        for (int i = 0; i < 3; i++) begin
            take_bits(dw, d);
            send(hash_table_pkg::OP_WRITE, keys[i], d, 0);
        end
        send(hash_table_pkg::OP_READ, keys[0], '0, 0);
        send(hash_table_pkg::OP_READ, keys[1], '0, 0);
        for (int i = 0; i < 3; i++) begin
            send(hash_table_pkg::OP_DELETE, keys[i], '0, 0);
        end
        idle(4);

        test_name = "write_read";
        for (int i = 3; i < 8; i++) begin
            take_bits(kw, r);
            keys[i] = r[kw-1:0];
        end
        for (int i = 3; i < 7; i++) begin
            take_bits(dw, d);
            send(hash_table_pkg::OP_WRITE, keys[i], d, 0);
        end
        for (int i = 3; i < 7; i++) begin
            send(hash_table_pkg::OP_READ, keys[i], '0, 0);
        end
        send(hash_table_pkg::OP_READ, keys[3] ^ 8'h5a, '0, 0);
        send(hash_table_pkg::OP_READ, keys[4] ^ 8'hc3, '0, 0);
        idle(4);

        test_name = "key_present";
        send(hash_table_pkg::OP_WRITE, keys[3], 16'hbeef, 0);
        send(hash_table_pkg::OP_READ, keys[3], '0, 0);
        idle(4);

        test_name = "delete";
        send(hash_table_pkg::OP_DELETE, keys[3], '0, 0);
        send(hash_table_pkg::OP_DELETE, keys[4], '0, 0);
        send(hash_table_pkg::OP_READ, keys[3], '0, 0);
        send(hash_table_pkg::OP_READ, keys[4], '0, 0);
        send(hash_table_pkg::OP_DELETE, keys[3], '0, 0);
        idle(4);

        test_name = "forwarding";
        send(hash_table_pkg::OP_WRITE, keys[7], 16'h1234, 0);
        send(hash_table_pkg::OP_READ, keys[7], '0, 0);
        send(hash_table_pkg::OP_DELETE, keys[7], '0, 0);
        send(hash_table_pkg::OP_WRITE, keys[7], 16'h5678, 0);
        send(hash_table_pkg::OP_READ, keys[7], '0, 0);
        idle(4);

        test_name = "stall";  // small key space so ops hit each other
        for (int i = 0; i < 24; i++) begin
            take_bits(2, r);
            take_bits(3, d);
            k = kw'(d[2:0]);
            take_bits(dw, d);
            send(hash_table_pkg::op_e'(r[1:0]), k, d, 0);
            take_bits(2, r);
            if (r[1:0] != 2'd0) begin
                send(hash_table_pkg::OP_READ, kw'(i % 8), '0, int'(r[1:0]));
            end
        end
        idle(6);

        assert_fails = hash_table_inst.asserts_inst.fail_count;
        if (exp_q.size() != 0) begin
            $display("%0d expected results never came out", exp_q.size());
            other_errors++;
        end
        $display("value errors %0d, other errors %0d, assertion failures %0d",
                 val_errors, other_errors, assert_fails);
        if (val_errors == 0 && other_errors == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+design
design/hash_table_pkg.sv
design/h3_hash.sv
design/bucket_store.sv
design/forward_unit.sv
design/table_controller.sv
design/hash_table.sv
dv/hash_table_asserts.sv
dv/hash_table_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it and check the log"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
		-f all.f --top-module hash_table_tb -Mdir obj_dir
	./obj_dir/Vhash_table_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
